//--- logic/pic_map_pkg.sv
// interrupt controller address map
package pic_map_pkg;

   ////////////////////////////////////////
   // bus geometry
   ////////////////////////////////////////

   // data and address width of the strobe bus
   localparam int BUS_WIDTH = 32;

   // default placement of the register space
   localparam logic [BUS_WIDTH-1:0] PIC_DEFAULT_BASE = 32'hf00c_0000;

   ////////////////////////////////////////
   // region offsets from the base
   ////////////////////////////////////////

   // per-source priority, one word each
   localparam logic [BUS_WIDTH-1:0] PRIORITY_OFFSET  = 32'h0000_0000;
   // pending bits, 32 sources per word
   localparam logic [BUS_WIDTH-1:0] PENDING_OFFSET   = 32'h0000_1000;
   // per-source enable bit
   localparam logic [BUS_WIDTH-1:0] ENABLE_OFFSET    = 32'h0000_2000;
   // single global register, priority order in bit 0
   localparam logic [BUS_WIDTH-1:0] CONFIG_OFFSET    = 32'h0000_3000;
   // per-source gateway polarity and type
   localparam logic [BUS_WIDTH-1:0] GW_CONFIG_OFFSET = 32'h0000_4000;
   // write-only, clears the edge latch of a source
   localparam logic [BUS_WIDTH-1:0] GW_CLEAR_OFFSET  = 32'h0000_5000;

   ////////////////////////////////////////
   // field widths
   ////////////////////////////////////////

   localparam int PRIORITY_BITS = 4;
   localparam int ID_BITS       = 8;

   // top of the raw priority range
   localparam int MAX_PRIORITY  = 15;

endpackage

//--- logic/pic_types_pkg.sv
// interrupt controller data types
package pic_types_pkg;

   import pic_map_pkg::*;

   ////////////////////////////////////////
   // value types
   ////////////////////////////////////////

   // raw or order-adjusted priority
   typedef logic [PRIORITY_BITS-1:0] priority_t;

   // interrupt id, 0 means none
   typedef logic [ID_BITS-1:0] claim_id_t;

   ////////////////////////////////////////
   // encodings
   ////////////////////////////////////////

   // target of a captured bus request
   typedef enum logic [2:0] {
      reg_none,
      reg_priority,
      reg_enable,
      reg_pending,
      reg_config,
      reg_gw_config,
      reg_gw_clear
   } reg_kind_e;

   // gateway behaviour, stored in bit 1 of the gateway config word
   typedef enum logic {
      gw_level = 1'b0,
      gw_edge  = 1'b1
   } gw_type_e;

endpackage

//--- logic/pic_cfg_if.sv
// interrupt controller configuration bundle
`timescale 1ns/100ps

interface pic_cfg_if
   import pic_types_pkg::*;
#(
   parameter int TOTAL_INT = 32
) ();

   // per-source priority as written by software
   priority_t [TOTAL_INT-1:0] src_priority;
   // per-source enable
   logic      [TOTAL_INT-1:0] src_enable;
   // 1 inverts the synchronized input
   logic      [TOTAL_INT-1:0] gw_polarity;
   // level or edge gateway
   gw_type_e                  gw_type [TOTAL_INT];
   // single-cycle strobe from a clear write
   logic      [TOTAL_INT-1:0] gw_clear;
   // global order, 1 means 0 is the most urgent
   logic                      priord;
   // gateway outputs
   logic      [TOTAL_INT-1:0] pending;

   // register bank owns every configuration field
   modport regs (
      output src_priority, src_enable, gw_polarity, gw_type, gw_clear, priord,
      input  pending
   );

   // gateways only see their own controls
   modport gateways (
      input  gw_polarity, gw_type, gw_clear,
      output pending
   );

   // arbiter needs no gateway controls
   modport arbiter (
      input  src_priority, src_enable, priord, pending
   );

endinterface

//--- logic/pic_regs.sv
// interrupt controller register bank
`timescale 1ns/100ps

module pic_regs
   import pic_map_pkg::*;
   import pic_types_pkg::*;
#(
   parameter int                   TOTAL_INT     = 32,
   parameter logic [BUS_WIDTH-1:0] PIC_BASE_ADDR = PIC_DEFAULT_BASE
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [BUS_WIDTH-1:0] picm_addr,
   input  logic [BUS_WIDTH-1:0] picm_wr_data,
   input  logic                 picm_wren,
   input  logic                 picm_rden,
   output logic [BUS_WIDTH-1:0] picm_rd_data,
   pic_cfg_if.regs              cfg
);

   // source index bits within a region
   localparam int IDX_BITS   = $clog2(TOTAL_INT);
   // pending is read 32 sources at a time
   localparam int PEND_WORDS = (TOTAL_INT + 31) / 32;
   // each region spans 4 KB
   localparam int REGION_LSB = 12;

   // captured request
   logic                  wren_q;
   logic                  rden_q;
   logic [BUS_WIDTH-1:0]  addr_q;
   logic [BUS_WIDTH-1:0]  data_q;

   // decode
   logic [BUS_WIDTH-1:0]  reg_offset;
   logic [BUS_WIDTH-1:0]  region;
   logic [REGION_LSB-3:0] slot;
   logic                  src_ok;
   logic [IDX_BITS-1:0]   src_idx;
   reg_kind_e             kind;

   // configuration for sources 1 and up
   priority_t [TOTAL_INT-1:1] prio_q;
   logic      [TOTAL_INT-1:1] enable_q;
   logic      [TOTAL_INT-1:1] polarity_q;
   gw_type_e                  type_q [TOTAL_INT-1:1];
   logic                      priord_q;
   logic      [TOTAL_INT-1:1] clr;

   // read path
   logic [PEND_WORDS*BUS_WIDTH-1:0] pend_flat;
   logic [BUS_WIDTH-1:0]            rd_data;

   ////////////////////////////////////////
   // request capture
   ////////////////////////////////////////

   // request strobes
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wren_q <= 1'b0;
         rden_q <= 1'b0;
      end else begin
         wren_q <= picm_wren;
         rden_q <= picm_rden;
      end
   end

   // address and data only load with a request
   always_ff @(posedge clk) begin
      if (picm_wren || picm_rden) begin
         addr_q <= picm_addr;
      end
      if (picm_wren) begin
         data_q <= picm_wr_data;
      end
   end

   ////////////////////////////////////////
   // address decode
   ////////////////////////////////////////

   always_comb begin
      reg_offset = addr_q - PIC_BASE_ADDR;
      region     = {reg_offset[BUS_WIDTH-1:REGION_LSB], {REGION_LSB{1'b0}}};
      // word index inside the region without the byte lanes
      slot       = reg_offset[REGION_LSB-1:2];
      // source 0 is reserved and decodes as unmapped
      src_ok     = (slot != '0) && (slot < TOTAL_INT);
      kind       = reg_none;
      case (region)
         PRIORITY_OFFSET:  if (src_ok) kind = reg_priority;
         PENDING_OFFSET:   if (slot < PEND_WORDS) kind = reg_pending;
         ENABLE_OFFSET:    if (src_ok) kind = reg_enable;
         CONFIG_OFFSET:    if (slot == '0) kind = reg_config;
         GW_CONFIG_OFFSET: if (src_ok) kind = reg_gw_config;
         GW_CLEAR_OFFSET:  if (src_ok) kind = reg_gw_clear;
         default:          kind = reg_none;
      endcase
   end

   assign src_idx = slot[IDX_BITS-1:0];

   ////////////////////////////////////////
   // configuration registers
   ////////////////////////////////////////

   // writes land one edge after capture
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         prio_q     <= '0;
         enable_q   <= '0;
         polarity_q <= '0;
         type_q     <= '{default: gw_level};
         priord_q   <= 1'b0;
      end else if (wren_q) begin
         case (kind)
            reg_priority: prio_q[src_idx] <= data_q[PRIORITY_BITS-1:0];
            reg_enable:   enable_q[src_idx] <= data_q[0];
            reg_gw_config: begin
               polarity_q[src_idx] <= data_q[0];
               type_q[src_idx]     <= gw_type_e'(data_q[1]);
            end
            reg_config:   priord_q <= data_q[0];
            // pending is read-only and clear is a strobe
            default: ;
         endcase
      end
   end

   // clear strobe live for the cycle after capture
   always_comb begin
      clr = '0;
      if (wren_q && (kind == reg_gw_clear)) begin
         clr[src_idx] = 1'b1;
      end
   end

   // drive the bundle with source 0 tied off
   assign cfg.src_priority = {prio_q, priority_t'(0)};
   assign cfg.src_enable   = {enable_q, 1'b0};
   assign cfg.gw_polarity  = {polarity_q, 1'b0};
   assign cfg.gw_clear     = {clr, 1'b0};
   assign cfg.priord       = priord_q;

   assign cfg.gw_type[0] = gw_level;
   for (genvar i = 1; i < TOTAL_INT; i++) begin : g_type
      assign cfg.gw_type[i] = type_q[i];
   end

   ////////////////////////////////////////
   // read data
   ////////////////////////////////////////

   // pending padded to whole words
   always_comb begin
      pend_flat                = '0;
      pend_flat[TOTAL_INT-1:0] = cfg.pending;
   end

   // combinational from the capture flops and zero without a read
   always_comb begin
      rd_data = '0;
      if (rden_q) begin
         case (kind)
            reg_priority:  rd_data[PRIORITY_BITS-1:0] = prio_q[src_idx];
            reg_enable:    rd_data[0] = enable_q[src_idx];
            reg_gw_config: rd_data[1:0] = {type_q[src_idx], polarity_q[src_idx]};
            reg_config:    rd_data[0] = priord_q;
            reg_pending:   rd_data = pend_flat[slot*BUS_WIDTH +: BUS_WIDTH];
            default:       rd_data = '0;
         endcase
      end
   end

   assign picm_rd_data = rd_data;

   // bus master never issues both strobes together
   a_single_strobe : assert property (
      @(posedge clk) disable iff (!rst_n) !(wren_q && rden_q)
   );

endmodule

//--- logic/pic_gateways.sv
// interrupt source gateways
`timescale 1ns/100ps

module pic_gateways
   import pic_types_pkg::*;
#(
   parameter int TOTAL_INT = 32
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [TOTAL_INT-1:0] extintsrc_req,
   pic_cfg_if.gateways          cfg
);

   // source 0 is reserved, nothing below is built for it
   logic [TOTAL_INT-1:1] sync1_q;
   logic [TOTAL_INT-1:1] sync2_q;
   logic [TOTAL_INT-1:1] level;
   logic [TOTAL_INT-1:1] latch_q;
   logic [TOTAL_INT-1:1] pend;

   ////////////////////////////////////////
   // input synchronizers
   ////////////////////////////////////////

   // two flops, sources are asynchronous to clk
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync1_q <= '0;
         sync2_q <= '0;
      end else begin
         sync1_q <= extintsrc_req[TOTAL_INT-1:1];
         sync2_q <= sync1_q;
      end
   end

   ////////////////////////////////////////
   // gateways
   ////////////////////////////////////////

   // polarity 1 makes a low input active
   assign level = sync2_q ^ cfg.gw_polarity[TOTAL_INT-1:1];

   // sets on any active level, held until software clears it
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         latch_q <= '0;
      end else begin
         latch_q <= level | (latch_q & ~cfg.gw_clear[TOTAL_INT-1:1]);
      end
   end

   // only edge gateways see the latch
   always_comb begin
      for (int i = 1; i < TOTAL_INT; i++) begin
         if (cfg.gw_type[i] == gw_edge) begin
            pend[i] = level[i] | latch_q[i];
         end else begin
            pend[i] = level[i];
         end
      end
   end

   // source 0 never pends
   assign cfg.pending = {pend, 1'b0};

   // the register bank clears at most one source per write
   a_clear_onehot : assert property (
      @(posedge clk) disable iff (!rst_n) $onehot0(cfg.gw_clear)
   );

endmodule

//--- logic/pic_arbiter.sv
// interrupt priority arbiter
`timescale 1ns/100ps

module pic_arbiter
   import pic_map_pkg::*;
   import pic_types_pkg::*;
#(
   parameter int TOTAL_INT = 32
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [PRIORITY_BITS-1:0] meicurpl,
   input  logic [PRIORITY_BITS-1:0] meipt,
   output logic                     mexintpend,
   output logic                     mhwakeup,
   output claim_id_t                claimid,
   output priority_t                pl,
   pic_cfg_if.arbiter               cfg
);

   // tree depth and leaf count, padded to a power of two
   localparam int LEVELS = $clog2(TOTAL_INT);
   localparam int LEAVES = 2 ** LEVELS;

   // one contender in the tree
   typedef struct packed {
      priority_t prio;
      claim_id_t id;
   } cand_t;

   priority_t [TOTAL_INT-1:0] eff_prio;
   cand_t                     cand [LEAVES];
   cand_t                     win;

   priority_t pl_next;
   priority_t meipt_eff;
   priority_t meicurpl_eff;
   priority_t max_pl;
   logic      mexintpend_next;
   logic      mhwakeup_next;

   // higher priority wins, a tie keeps the left (lower id) side
   function automatic cand_t pick(input cand_t a, input cand_t b);
      return (b.prio > a.prio) ? b : a;
   endfunction

   ////////////////////////////////////////
   // effective priority
   ////////////////////////////////////////

   // reversed order flips priorities so larger always wins
   always_comb begin
      for (int i = 0; i < TOTAL_INT; i++) begin
         if (cfg.pending[i] && cfg.src_enable[i]) begin
            eff_prio[i] = cfg.priord ? ~cfg.src_priority[i] : cfg.src_priority[i];
         end else begin
            eff_prio[i] = '0;
         end
      end
   end

   ////////////////////////////////////////
   // comparison tree
   ////////////////////////////////////////

   always_comb begin
      // leaves, padding entries can never win
      for (int i = 0; i < LEAVES; i++) begin
         if (i < TOTAL_INT) begin
            cand[i] = '{prio: eff_prio[i], id: claim_id_t'(i)};
         end else begin
            cand[i] = '{prio: '0, id: '0};
         end
      end
      // reduce in place, pairs move down to the front
      for (int l = 0; l < LEVELS; l++) begin
         for (int i = 0; i < (LEAVES >> (l + 1)); i++) begin
            cand[i] = pick(cand[2*i], cand[2*i+1]);
         end
      end
      // nothing eligible leaves source 0 at priority 0
      win = cand[0];
   end

   ////////////////////////////////////////
   // threshold and wake-up
   ////////////////////////////////////////

   // back to the software view of priority
   assign pl_next = cfg.priord ? ~win.prio : win.prio;

   // thresholds compared in the same flipped space as win
   assign meipt_eff    = cfg.priord ? ~meipt : meipt;
   assign meicurpl_eff = cfg.priord ? ~meicurpl : meicurpl;

   assign mexintpend_next = (win.prio > meipt_eff) && (win.prio > meicurpl_eff);

   // most urgent level depends on the order
   assign max_pl        = cfg.priord ? priority_t'(0) : priority_t'(MAX_PRIORITY);
   assign mhwakeup_next = (pl_next == max_pl);

   ////////////////////////////////////////
   // output registers
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         claimid    <= '0;
         pl         <= '0;
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
      end else begin
         claimid    <= win.id;
         pl         <= pl_next;
         mexintpend <= mexintpend_next;
         mhwakeup   <= mhwakeup_next;
      end
   end

   // an interrupt to the core always names a real source
   a_claim_valid : assert property (
      @(posedge clk) disable iff (!rst_n) mexintpend |-> (claimid != '0)
   );

endmodule

//--- logic/pic_top.sv
// programmable interrupt controller
`timescale 1ns/100ps

module pic_top
   import pic_map_pkg::*;
#(
   parameter int                   TOTAL_INT     = 32,
   parameter logic [BUS_WIDTH-1:0] PIC_BASE_ADDR = PIC_DEFAULT_BASE
) (
   input  logic                     clk,
   input  logic                     rst_n,
   // external sources, bit 0 reserved
   input  logic [TOTAL_INT-1:0]     extintsrc_req,
   // register bus
   input  logic [BUS_WIDTH-1:0]     picm_addr,
   input  logic [BUS_WIDTH-1:0]     picm_wr_data,
   input  logic                     picm_wren,
   input  logic                     picm_rden,
   output logic [BUS_WIDTH-1:0]     picm_rd_data,
   // core side
   input  logic [PRIORITY_BITS-1:0] meicurpl,
   input  logic [PRIORITY_BITS-1:0] meipt,
   output logic                     mexintpend,
   output logic                     mhwakeup,
   output logic [ID_BITS-1:0]       claimid,
   output logic [PRIORITY_BITS-1:0] pl
);

   // configuration out, pending back
   pic_cfg_if #(.TOTAL_INT(TOTAL_INT)) cfg_if ();

   // register bank
   pic_regs #(
      .TOTAL_INT     (TOTAL_INT),
      .PIC_BASE_ADDR (PIC_BASE_ADDR)
   ) regs_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .picm_addr    (picm_addr),
      .picm_wr_data (picm_wr_data),
      .picm_wren    (picm_wren),
      .picm_rden    (picm_rden),
      .picm_rd_data (picm_rd_data),
      .cfg          (cfg_if.regs)
   );

   // synchronizers and gateways
   pic_gateways #(
      .TOTAL_INT (TOTAL_INT)
   ) gateways_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .extintsrc_req (extintsrc_req),
      .cfg           (cfg_if.gateways)
   );

   // winner selection and core outputs
   pic_arbiter #(
      .TOTAL_INT (TOTAL_INT)
   ) arbiter_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .meicurpl   (meicurpl),
      .meipt      (meipt),
      .mexintpend (mexintpend),
      .mhwakeup   (mhwakeup),
      .claimid    (claimid),
      .pl         (pl),
      .cfg        (cfg_if.arbiter)
   );

endmodule

//--- testbench/tb_pic_tests.svh
// interrupt controller directed tests

// reset values, field masking, reserved source 0
task automatic test_register_access();
   test_name = "register_access";
   check_outputs(0, 0, 1'b0, 1'b0);
   for (int i = 0; i < TOTAL_INT; i++) begin
      read_and_compare("priority at reset", src_addr(PRIORITY_OFFSET, i), 32'h0);
      read_and_compare("enable at reset", src_addr(ENABLE_OFFSET, i), 32'h0);
      read_and_compare("gw config at reset", src_addr(GW_CONFIG_OFFSET, i), 32'h0);
   end
   read_and_compare("pending at reset", src_addr(PENDING_OFFSET, 0), 32'h0);
   read_and_compare("config at reset", src_addr(CONFIG_OFFSET, 0), 32'h0);
   // upper bits dropped on write
   bus_write(src_addr(PRIORITY_OFFSET, 3), 32'hffff_fffa);
   read_and_compare("priority masked", src_addr(PRIORITY_OFFSET, 3), 32'ha);
   bus_write(src_addr(ENABLE_OFFSET, 3), 32'hffff_fffe);
   read_and_compare("enable masked", src_addr(ENABLE_OFFSET, 3), 32'h0);
   bus_write(src_addr(ENABLE_OFFSET, 3), 32'h0000_0003);
   read_and_compare("enable set", src_addr(ENABLE_OFFSET, 3), 32'h1);
   bus_write(src_addr(GW_CONFIG_OFFSET, 3), 32'hffff_fffe);
   read_and_compare("gw config masked", src_addr(GW_CONFIG_OFFSET, 3), 32'h2);
   bus_write(src_addr(CONFIG_OFFSET, 0), 32'h0000_0007);
   read_and_compare("order bit set", src_addr(CONFIG_OFFSET, 0), 32'h1);
   bus_write(src_addr(CONFIG_OFFSET, 0), 32'h0);
   // source 0 has no storage
   configure_source(0, 15, 1'b1, 2'b11);
   read_and_compare("source 0 priority", src_addr(PRIORITY_OFFSET, 0), 32'h0);
   read_and_compare("source 0 enable", src_addr(ENABLE_OFFSET, 0), 32'h0);
   read_and_compare("source 0 gw config", src_addr(GW_CONFIG_OFFSET, 0), 32'h0);
   configure_source(3, 0, 1'b0, 2'b00);
endtask

// single level source against both thresholds
task automatic test_level_threshold();
   test_name = "level_threshold";
   configure_source(5, 7, 1'b1, 2'b00);
   drive_sources(32'h0000_0020);
   check_outputs(5, 7, 1'b1, 1'b0);
   drive_thresholds(7, 0);
   check_outputs(5, 7, 1'b0, 1'b0);
   drive_thresholds(6, 0);
   check_outputs(5, 7, 1'b1, 1'b0);
   drive_thresholds(0, 7);
   check_outputs(5, 7, 1'b0, 1'b0);
   drive_thresholds(6, 6);
   check_outputs(5, 7, 1'b1, 1'b0);
   drive_thresholds(0, 0);
   // level source drops straight away
   drive_sources(32'h0);
   check_outputs(0, 0, 1'b0, 1'b0);
   bus_write(src_addr(ENABLE_OFFSET, 5), 32'h0);
endtask

// priority wins, ties to lower id
task automatic test_arbitration();
   test_name = "arbitration";
   configure_source(3, 4, 1'b1, 2'b00);
   configure_source(9, 6, 1'b1, 2'b00);
   configure_source(12, 6, 1'b1, 2'b00);
   configure_source(20, 2, 1'b1, 2'b00);
   // sources 3, 9, 12, 20
   drive_sources(32'h0010_1208);
   check_outputs(9, 6, 1'b1, 1'b0);
   bus_write(src_addr(ENABLE_OFFSET, 9), 32'h0);
   wait_config_latency();
   check_outputs(12, 6, 1'b1, 1'b0);
   bus_write(src_addr(ENABLE_OFFSET, 12), 32'h0);
   wait_config_latency();
   check_outputs(3, 4, 1'b1, 1'b0);
   // 20 ties with 3 and loses on id
   bus_write(src_addr(PRIORITY_OFFSET, 20), 32'h4);
   wait_config_latency();
   check_outputs(3, 4, 1'b1, 1'b0);
   bus_write(src_addr(ENABLE_OFFSET, 3), 32'h0);
   wait_config_latency();
   check_outputs(20, 4, 1'b1, 1'b0);
   drive_sources(32'h0);
   check_outputs(0, 0, 1'b0, 1'b0);
   bus_write(src_addr(ENABLE_OFFSET, 20), 32'h0);
endtask

// edge latch with clear, then active-low level
task automatic test_edge_polarity();
   test_name = "edge_polarity";
   configure_source(7, 3, 1'b1, 2'b10);
   drive_sources(32'h0000_0080);
   check_outputs(7, 3, 1'b1, 1'b0);
   // latch keeps it pending
   drive_sources(32'h0);
   check_outputs(7, 3, 1'b1, 1'b0);
   read_and_compare("pending held", src_addr(PENDING_OFFSET, 0), 32'h0000_0080);
   bus_write(src_addr(GW_CLEAR_OFFSET, 7), 32'h1);
   read_and_compare("pending after clear", src_addr(PENDING_OFFSET, 0), 32'h0);
   wait_config_latency();
   check_outputs(0, 0, 1'b0, 1'b0);
   // input low is active with polarity 1
   configure_source(10, 2, 1'b1, 2'b01);
   wait_config_latency();
   check_outputs(10, 2, 1'b1, 1'b0);
   read_and_compare("active low pending", src_addr(PENDING_OFFSET, 0), 32'h0000_0400);
   drive_sources(32'h0000_0400);
   check_outputs(0, 0, 1'b0, 1'b0);
   read_and_compare("active low idle", src_addr(PENDING_OFFSET, 0), 32'h0);
   configure_source(10, 0, 1'b0, 2'b00);
   configure_source(7, 0, 1'b0, 2'b00);
   drive_sources(32'h0);
endtask

// wake-up at max priority, then order bit flipped
task automatic test_reverse_order();
   test_name = "reverse_order";
   configure_source(15, 15, 1'b1, 2'b00);
   drive_sources(32'h0000_8000);
   check_outputs(15, 15, 1'b1, 1'b1);
   drive_sources(32'h0);
   bus_write(src_addr(ENABLE_OFFSET, 15), 32'h0);
   configure_source(4, 0, 1'b1, 2'b00);
   configure_source(6, 3, 1'b1, 2'b00);
   drive_sources(32'h0000_0050);
   check_outputs(6, 3, 1'b1, 1'b0);
   // 0 is now the most urgent level
   bus_write(src_addr(CONFIG_OFFSET, 0), 32'h1);
   wait_config_latency();
   check_outputs(4, 0, 1'b0, 1'b1);
   drive_thresholds(1, 1);
   check_outputs(4, 0, 1'b1, 1'b1);
   drive_thresholds(1, 0);
   check_outputs(4, 0, 1'b0, 1'b1);
   drive_thresholds(4, 4);
   bus_write(src_addr(ENABLE_OFFSET, 4), 32'h0);
   wait_config_latency();
   check_outputs(6, 3, 1'b1, 1'b0);
   drive_thresholds(3, 4);
   check_outputs(6, 3, 1'b0, 1'b0);
   drive_thresholds(0, 0);
   bus_write(src_addr(CONFIG_OFFSET, 0), 32'h0);
   drive_sources(32'h0);
   bus_write(src_addr(ENABLE_OFFSET, 6), 32'h0);
   wait_config_latency();
   check_outputs(0, 0, 1'b0, 1'b0);
endtask

//--- testbench/tb_pic_top.sv
// interrupt controller testbench
`timescale 1ns/100ps

module tb_pic_top
   import pic_map_pkg::*;
();

   localparam int TOTAL_INT = 32;
   // 8 ns clock
   localparam int CLK_HALF = 4;
   // about four times the cycles the full sequence needs
   localparam int WATCHDOG_CYCLES = 2000;

   logic                     clk;
   logic                     rst_n;
   logic [TOTAL_INT-1:0]     extintsrc_req;
   logic [BUS_WIDTH-1:0]     picm_addr;
   logic [BUS_WIDTH-1:0]     picm_wr_data;
   logic                     picm_wren;
   logic                     picm_rden;
   logic [BUS_WIDTH-1:0]     picm_rd_data;
   logic [PRIORITY_BITS-1:0] meicurpl;
   logic [PRIORITY_BITS-1:0] meipt;
   logic                     mexintpend;
   logic                     mhwakeup;
   logic [ID_BITS-1:0]       claimid;
   logic [PRIORITY_BITS-1:0] pl;

   // name of the running test, shown in error lines
   string test_name;

   pic_top #(
      .TOTAL_INT (TOTAL_INT)
   ) pic_top_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .extintsrc_req (extintsrc_req),
      .picm_addr     (picm_addr),
      .picm_wr_data  (picm_wr_data),
      .picm_wren     (picm_wren),
      .picm_rden     (picm_rden),
      .picm_rd_data  (picm_rd_data),
      .meicurpl      (meicurpl),
      .meipt         (meipt),
      .mexintpend    (mexintpend),
      .mhwakeup      (mhwakeup),
      .claimid       (claimid),
      .pl            (pl)
   );

   ////////////////////////////////////////
   // clock and watchdog
   ////////////////////////////////////////

   initial clk = 1'b0;
   always #(CLK_HALF) clk = ~clk;

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: test sequence did not complete in %0d cycles", WATCHDOG_CYCLES);
      $display("Finished with errors");
      $fatal(1, "watchdog expired");
   end

   ////////////////////////////////////////
   // bus and check helpers
   ////////////////////////////////////////

   // register address of a source or word index
   function automatic logic [31:0] src_addr(input logic [31:0] offset, input int idx);
      return PIC_DEFAULT_BASE + offset + 32'(4 * idx);
   endfunction

   // one-cycle write strobe, driven 1 ns after the edge
   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
      @(posedge clk);
      #1;
      picm_wren    = 1'b1;
      picm_addr    = addr;
      picm_wr_data = data;
      @(posedge clk);
      #1;
      picm_wren = 1'b0;
   endtask

   // read data is valid in the cycle after capture
   task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
      @(posedge clk);
      #1;
      picm_rden = 1'b1;
      picm_addr = addr;
      @(posedge clk);
      #1;
      picm_rden = 1'b0;
      #2;
      data = picm_rd_data;
   endtask

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
         $display("Finished with errors");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic read_and_compare(input string what, input logic [31:0] addr,
                                   input logic [31:0] exp);
      logic [31:0] data;
      bus_read(addr, data);
      check_value(what, exp, data);
   endtask

   // all four core-side outputs at once
   task automatic check_outputs(input int id, input int prio, input logic pend,
                                input logic wake);
      check_value("claimid", 32'(id), 32'(claimid));
      check_value("pl", 32'(prio), 32'(pl));
      check_value("mexintpend", 32'(pend), 32'(mexintpend));
      check_value("mhwakeup", 32'(wake), 32'(mhwakeup));
   endtask

   // source edge to outputs, two sync flops then output regs
   task automatic wait_source_latency();
      repeat (3) @(posedge clk);
      #1;
   endtask

   // register update then output regs
   task automatic wait_config_latency();
      repeat (2) @(posedge clk);
      #1;
   endtask

   task automatic drive_sources(input logic [TOTAL_INT-1:0] req);
      @(posedge clk);
      #1;
      extintsrc_req = req;
      wait_source_latency();
   endtask

   task automatic drive_thresholds(input int pt, input int curpl);
      @(posedge clk);
      #1;
      meipt    = PRIORITY_BITS'(pt);
      meicurpl = PRIORITY_BITS'(curpl);
      wait_config_latency();
   endtask

   // priority, enable and gateway config of one source
   task automatic configure_source(input int idx, input int prio, input logic en,
                                   input logic [1:0] gw);
      bus_write(src_addr(PRIORITY_OFFSET, idx), 32'(prio));
      bus_write(src_addr(ENABLE_OFFSET, idx), 32'(en));
      bus_write(src_addr(GW_CONFIG_OFFSET, idx), 32'(gw));
   endtask

   `include "tb_pic_tests.svh"

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial begin
      extintsrc_req = '0;
      picm_addr     = '0;
      picm_wr_data  = '0;
      picm_wren     = 1'b0;
      picm_rden     = 1'b0;
      meicurpl      = '0;
      meipt         = '0;
      rst_n         = 1'b0;
      test_name     = "reset";
      // reset held for 3 cycles
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      test_register_access();
      test_level_threshold();
      test_arbitration();
      test_edge_polarity();
      test_reverse_order();
      $display("Finished with no errors");
      $finish;
   end

endmodule

//--- tb.f
+incdir+testbench
logic/pic_map_pkg.sv
logic/pic_types_pkg.sv
logic/pic_cfg_if.sv
logic/pic_regs.sv
logic/pic_gateways.sv
logic/pic_arbiter.sv
logic/pic_top.sv
testbench/tb_pic_top.sv
